// ==== build.f ====
+incdir+hdl
hdl/pcs_pkg.sv
hdl/an_pkg.sv
hdl/enc_8b10b.sv
hdl/dec_8b10b.sv
hdl/tx_pcs.sv
hdl/rx_pcs.sv
hdl/negotiate.sv
hdl/gmii_link.sv
tb/tb_gmii_link.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP      = tb_gmii_link
FILELIST = build.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb/tb_gmii_link.sv ====
// Testbench for the GMII PCS link
// Serial loopback with error injection, directed tests and a watchdog
`default_nettype none
`include "gmii_link_defines.svh"

module tb_gmii_link;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMER_TICKS = 200;
	localparam int MAX_FRAME = 64;
	localparam int N_FRAMES = 4;
	localparam int GAP = 32; // Idle cycles budgeted around each frame
	localparam int WATCHDOG_CYCLES = 2 * (8 * TIMER_TICKS + N_FRAMES * (MAX_FRAME + GAP));
	localparam pcs_pkg::code_group_t K28_5_RDN = 10'b001111_1010; // K28.5 at negative RD

	logic                 GTX_CLK, arst_n;
	pcs_pkg::octet_t      TXD, RXD;
	logic                 TX_EN, TX_ER, RX_DV, RX_ER;
	pcs_pkg::code_group_t txdata, rxdata;
	logic                 rx_err_los, an_bypass, operate;
	an_pkg::lacr_t        lacr_rx, ack_word;
	an_pkg::an_status_t   an_status;
	logic [31:0]          rng;
	logic [7:0]           frame[$]; // Octets of the frame in flight
	logic                 inject_armed; // Corrupt next unbalanced group on the line
	int                   stb_count;

	gmii_link #(.TIMER_TICKS(TIMER_TICKS)) i_gmii_link (
		.GTX_CLK(GTX_CLK), .arst_n(arst_n),
		.TXD(TXD), .TX_EN(TX_EN), .TX_ER(TX_ER),
		.RXD(RXD), .RX_DV(RX_DV), .RX_ER(RX_ER),
		.txdata(txdata), .rxdata(rxdata), .rx_err_los(rx_err_los),
		.an_bypass(an_bypass), .operate(operate),
		.lacr_rx(lacr_rx), .an_status(an_status)
	);

	initial begin
		GTX_CLK = 1'b0;
		forever #4 GTX_CLK = ~GTX_CLK; // 125 MHz
	end

	// One bit flip turns an unbalanced 6b block into 1 or 5 ones, which no code has
	function automatic logic [9:0] invalid_flip(input logic [9:0] cg);
		logic [5:0] s6;
		logic       want;
		s6 = cg[9:4];
		want = ($countones(s6) < 3); // Clear a one when ones are few
		for (int i = 0; i < 6; i++)
			if (s6[i] == want)
				return 10'(1) << (i + 4);
		return '0;
	endfunction

	// Serial loopback sampled on the falling edge away from the DUT edge
	always @(negedge GTX_CLK) begin
		if (inject_armed && $countones(txdata[9:4]) != 3) begin
			rxdata <= txdata ^ invalid_flip(txdata);
			inject_armed = 1'b0; // One shot
		end else begin
			rxdata <= txdata;
		end
	end

	// Counts config word strobes and keeps the last word taken in ACK_DETECT
	always @(negedge GTX_CLK) begin
		if (arst_n && i_gmii_link.lacr_rx_stb) begin
			stb_count++;
			if (an_status[2:0] == an_pkg::ACK_DETECT)
				ack_word = lacr_rx;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge GTX_CLK);
		$display("Watchdog expired, the tests did not finish in time");
		halt_run();
	end

	task automatic halt_run();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		if (got !== exp) begin
			$display("Fail %s exp %0h got %0h", name, exp, got);
			halt_run();
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic apply_reset(input logic bypass);
		@(negedge GTX_CLK);
		arst_n = 1'b0;
		an_bypass = bypass;
		repeat (10) @(negedge GTX_CLK);
		arst_n = 1'b1;
		stb_count = 0;
	endtask

	// Preamble octet first and random octets after it
	task automatic make_frame(input int len);
		frame.delete();
		frame.push_back(`PREAMBLE_OCTET);
		for (int i = 1; i < len; i++) begin
			rng = xorshift32(rng);
			frame.push_back(rng[7:0]);
		end
	endtask

	function automatic int random_length();
		rng = xorshift32(rng);
		return 8 + int'(rng % 57); // 8 to 64 octets
	endfunction

	task automatic send_frame(input int er_pos);
		for (int i = 0; i < frame.size(); i++) begin
			@(negedge GTX_CLK);
			TX_EN = 1'b1;
			TXD = frame[i];
			TX_ER = (i == er_pos);
		end
		@(negedge GTX_CLK);
		TX_EN = 1'b0;
		TX_ER = 1'b0;
		TXD = '0;
	endtask

	// The frame is the span of RX_DV with no gaps inside
	task automatic receive_frame(input int er_pos, input bit check_data, output bit er_seen);
		int n;
		int waited;
		n = 0;
		waited = 0;
		er_seen = 1'b0;
		@(negedge GTX_CLK);
		while (!RX_DV) begin
			waited++;
			if (waited > GAP * 2) begin
				$display("RX_DV never rose for the frame that was sent");
				halt_run();
			end
			@(negedge GTX_CLK);
		end
		while (RX_DV) begin
			if (n >= frame.size()) begin
				$display("Frame on RXD runs longer than the frame sent");
				halt_run();
			end
			if (check_data) begin
				check_value("RX_ER", 32'(n == er_pos), 32'(RX_ER));
				if (n != er_pos)
					check_value("RXD", frame[n], RXD); // Data under /V/ is undefined
			end
			er_seen |= RX_ER;
			n++;
			@(negedge GTX_CLK);
		end
		check_value("frame length", frame.size(), n);
	endtask

	task automatic wait_operate(input int max_cycles);
		int waited;
		waited = 0;
		while (!operate) begin
			waited++;
			if (waited > max_cycles) begin
				$display("operate did not rise, negotiation stalled");
				halt_run();
			end
			@(negedge GTX_CLK);
		end
	endtask

	task automatic reset_state();
		int waited;
		check_value("operate", 0, operate);
		check_value("RX_DV", 0, RX_DV);
		check_value("RX_ER", 0, RX_ER);
		check_value("an_status state", an_pkg::AN_RESTART, an_status[2:0]);
		@(negedge GTX_CLK);
		check_value("txdata", K28_5_RDN, txdata); // Config sets open with a comma
		waited = 0;
		while (!i_gmii_link.lacr_rx_stb) begin // Own zero words come back
			waited++;
			if (waited > GAP * 2) begin
				$display("No config word strobed after reset");
				halt_run();
			end
			@(negedge GTX_CLK);
		end
		check_value("lacr_rx", 0, lacr_rx);
	endtask

	task automatic negotiate_loopback();
		wait_operate(8 * TIMER_TICKS);
		check_value("an_status state", an_pkg::LINK_OK, an_status[2:0]);
		check_value("an_status ack", 1, an_status[3]);
		check_value("an_status los", 0, an_status[4]);
		check_value("an_status fd", 1, an_status[5]);
		check_value("an_status hd", 0, an_status[6]);
		check_value("an_status pause", 0, an_status[8:7]);
		check_value("lacr_rx acked", `AN_ABILITY | (16'h1 << `AN_ACK_BIT), ack_word);
	endtask

	task automatic deliver_frame();
		bit er_seen;
		make_frame(random_length());
		fork
			send_frame(-1);
			receive_frame(-1, 1'b1, er_seen);
		join
		repeat (GAP / 2) @(negedge GTX_CLK);
	endtask

	task automatic propagate_errors();
		bit er_seen;
		int er_pos;
		make_frame(random_length());
		rng = xorshift32(rng);
		er_pos = 2 + int'(rng % (frame.size() - 3)); // Clear of /S/ and the last octet
		fork
			send_frame(er_pos);
			receive_frame(er_pos, 1'b1, er_seen);
		join
		repeat (GAP / 2) @(negedge GTX_CLK);
		make_frame(40);
		fork
			send_frame(-1);
			receive_frame(-1, 1'b0, er_seen);
			begin
				repeat (10) @(posedge GTX_CLK); // Well inside the frame
				inject_armed = 1'b1;
			end
		join
		if (!er_seen) begin
			$display("Bit flip on the line did not raise RX_ER within the frame");
			halt_run();
		end
		repeat (GAP / 2) @(negedge GTX_CLK);
	endtask

	task automatic recover_from_los();
		@(negedge GTX_CLK);
		rx_err_los = 1'b1;
		repeat (8) @(negedge GTX_CLK);
		check_value("operate", 0, operate);
		check_value("an_status state", an_pkg::AN_RESTART, an_status[2:0]);
		check_value("an_status los", 1, an_status[4]);
		rx_err_los = 1'b0;
		wait_operate(8 * TIMER_TICKS);
		check_value("an_status state", an_pkg::LINK_OK, an_status[2:0]);
	endtask

	task automatic bypass_negotiation();
		bit er_seen;
		apply_reset(1'b1);
		repeat (16) @(negedge GTX_CLK);
		check_value("operate", 0, operate);
		make_frame(random_length());
		fork
			send_frame(-1);
			receive_frame(-1, 1'b1, er_seen);
		join
		repeat (GAP / 2) @(negedge GTX_CLK);
		check_value("operate", 0, operate);
		check_value("lacr_rx_stb count", 0, stb_count); // Idle only on the line
	endtask

	initial begin
		TXD = '0;
		TX_EN = 1'b0;
		TX_ER = 1'b0;
		rxdata = '0;
		rx_err_los = 1'b0;
		an_bypass = 1'b0;
		arst_n = 1'b0;
		inject_armed = 1'b0;
		stb_count = 0;
		ack_word = '0;
		rng = 32'h7204_e2e8;
		apply_reset(1'b0);
		reset_state();
		negotiate_loopback();
		deliver_frame();
		propagate_errors();
		recover_from_los();
		bypass_negotiation();
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/gmii_link.sv ====
// 1000BASE-X PCS link, PHY side of a GMII MAC
// Tx and Rx PCS, 8b/10b codecs and auto-negotiation on GTX_CLK
`default_nettype none
`include "gmii_link_defines.svh"

module gmii_link #(
	parameter int TIMER_TICKS = `AN_LINK_TIMER
) (
	input  wire                        GTX_CLK,
	input  wire                        arst_n,
	input  wire pcs_pkg::octet_t       TXD, // MAC side, directions seen from the PHY
	input  wire                        TX_EN,
	input  wire                        TX_ER,
	output pcs_pkg::octet_t            RXD,
	output logic                       RX_DV,
	output logic                       RX_ER,
	output pcs_pkg::code_group_t       txdata, // To serializer
	input  wire pcs_pkg::code_group_t  rxdata, // From deserializer, word aligned
	input  wire                        rx_err_los,
	input  wire                        an_bypass, // No config sets, frames pass at once
	output logic                       operate,
	output an_pkg::lacr_t              lacr_rx,
	output an_pkg::an_status_t         an_status
);

	pcs_pkg::char_t tx_char, rx_char;
	an_pkg::lacr_t  lacr_out;
	logic           tx_disp, code_err, disp_err;
	logic           lacr_send, lacr_rx_stb;
	logic           tx_en_gated, cfg_en;

	assign tx_en_gated = TX_EN & (operate | an_bypass); // Hold frames until link is up
	assign cfg_en = lacr_send & ~an_bypass;

	tx_pcs i_tx_pcs (
		.GTX_CLK(GTX_CLK), .arst_n(arst_n),
		.TXD(TXD), .tx_en(tx_en_gated), .TX_ER(TX_ER),
		.lacr_out(lacr_out), .cfg_en(cfg_en),
		.tx_disp(tx_disp), .tx_char(tx_char)
	);

	enc_8b10b i_enc_8b10b (
		.GTX_CLK(GTX_CLK), .arst_n(arst_n),
		.tx_char(tx_char), .txdata(txdata), .tx_disp(tx_disp)
	);

	dec_8b10b i_dec_8b10b (
		.GTX_CLK(GTX_CLK), .arst_n(arst_n),
		.rxdata(rxdata), .rx_char(rx_char),
		.code_err(code_err), .disp_err(disp_err)
	);

	rx_pcs i_rx_pcs (
		.GTX_CLK(GTX_CLK), .arst_n(arst_n),
		.rx_char(rx_char), .code_err(code_err), .disp_err(disp_err),
		.RXD(RXD), .RX_DV(RX_DV), .RX_ER(RX_ER),
		.lacr_rx(lacr_rx), .lacr_rx_stb(lacr_rx_stb)
	);

	negotiate #(.TIMER_TICKS(TIMER_TICKS)) i_negotiate (
		.GTX_CLK(GTX_CLK), .arst_n(arst_n),
		.los(rx_err_los),
		.lacr_in(lacr_rx), .lacr_in_stb(lacr_rx_stb),
		.lacr_out(lacr_out), .lacr_send(lacr_send),
		.operate(operate), .an_status(an_status)
	);

endmodule

`default_nettype wire

// ==== hdl/negotiate.sv ====
// Auto-negotiation
// Config word exchange with link timer, raises operate on LINK_OK
`default_nettype none
`include "gmii_link_defines.svh"

module negotiate #(
	parameter int TIMER_TICKS = `AN_LINK_TIMER
) (
	input  wire                 GTX_CLK,
	input  wire                 arst_n,
	input  wire                 los,
	input  wire an_pkg::lacr_t  lacr_in,
	input  wire                 lacr_in_stb,
	output an_pkg::lacr_t       lacr_out,
	output logic                lacr_send,
	output logic                operate,
	output an_pkg::an_status_t  an_status
);

	localparam int TW = $clog2(TIMER_TICKS + 1);
	localparam an_pkg::lacr_t ACK = an_pkg::lacr_t'(1) << `AN_ACK_BIT;

	an_pkg::an_state_e state;
	logic [TW-1:0]     timer;
	logic [1:0]        match_cnt; // Identical nonzero words in a row
	an_pkg::lacr_t     last_word, partner;
	logic              ack_seen, timer_done, same;

	assign timer_done = (timer == TW'(TIMER_TICKS - 1));
	assign same = (lacr_in == last_word) && (lacr_in != '0);

	assign lacr_out = (state == an_pkg::AN_RESTART) ? '0 :
		(state == an_pkg::ABILITY_DETECT) ? `AN_ABILITY : (`AN_ABILITY | ACK);
	assign lacr_send = (state != an_pkg::IDLE_DETECT) && (state != an_pkg::LINK_OK);
	assign operate = (state == an_pkg::LINK_OK);
	assign an_status = {partner[8:7], partner[6], partner[5], los, ack_seen, state};

	always_ff @(posedge GTX_CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= an_pkg::AN_RESTART;
			timer <= '0;
			match_cnt <= '0;
			last_word <= '0;
			partner <= '0;
			ack_seen <= 1'b0;
		end else if (los) begin
			state <= an_pkg::AN_RESTART;
			timer <= '0;
			match_cnt <= '0;
			ack_seen <= 1'b0;
		end else begin
			timer <= timer_done ? '0 : timer + 1'b1; // Free runs except where cleared
			if (lacr_in_stb)
				last_word <= lacr_in;
			case (state)
				an_pkg::AN_RESTART: begin
					ack_seen <= 1'b0;
					match_cnt <= '0;
					if (timer_done)
						state <= an_pkg::ABILITY_DETECT;
				end
				an_pkg::ABILITY_DETECT: begin
					if (lacr_in_stb) begin
						match_cnt <= same ? ((match_cnt == 2'd2) ? match_cnt : match_cnt + 1'b1) :
							{1'b0, lacr_in != '0};
						if (same && match_cnt == 2'd2) begin // Third in a row
							partner <= lacr_in;
							state <= an_pkg::ACK_DETECT;
						end
					end
				end
				an_pkg::ACK_DETECT: begin
					timer <= '0;
					if (lacr_in_stb && lacr_in[`AN_ACK_BIT] && (lacr_in & ~ACK) == (partner & ~ACK)) begin
						partner <= lacr_in;
						ack_seen <= 1'b1;
						state <= an_pkg::COMPLETE_ACK;
					end
				end
				an_pkg::COMPLETE_ACK: begin
					if (timer_done)
						state <= an_pkg::IDLE_DETECT;
				end
				an_pkg::IDLE_DETECT: begin
					// Tail of our own acked sets still in flight is not news
					if (lacr_in_stb && lacr_in != partner) begin
						timer <= '0;
						state <= an_pkg::AN_RESTART;
					end else if (timer_done) begin
						state <= an_pkg::LINK_OK;
					end
				end
				an_pkg::LINK_OK: begin
					if (lacr_in_stb && lacr_in == '0) begin // Partner restarted
						timer <= '0;
						state <= an_pkg::AN_RESTART;
					end
				end
				default: state <= an_pkg::AN_RESTART;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/rx_pcs.sv ====
// Receive PCS
// Frame delineation onto GMII, error marking, config word capture
`default_nettype none
`include "gmii_link_defines.svh"

module rx_pcs (
	input  wire                  GTX_CLK,
	input  wire                  arst_n,
	input  wire pcs_pkg::char_t  rx_char,
	input  wire                  code_err,
	input  wire                  disp_err,
	output pcs_pkg::octet_t      RXD,
	output logic                 RX_DV,
	output logic                 RX_ER,
	output an_pkg::lacr_t        lacr_rx,
	output logic                 lacr_rx_stb
);

	pcs_pkg::rx_state_e state;
	pcs_pkg::octet_t    d;
	logic               k, err;
	logic               is_comma, is_start, is_cfg;

	assign d = rx_char[7:0];
	assign k = rx_char[8];
	assign err = code_err || disp_err;
	assign is_comma = k && (d == `K28_5);
	assign is_start = k && (d == `K27_7);
	assign is_cfg = !k && (d == `D21_5 || d == `D2_2);

	always_ff @(posedge GTX_CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= pcs_pkg::WAIT_K;
			RXD <= '0;
			RX_DV <= 1'b0;
			RX_ER <= 1'b0;
			lacr_rx <= '0;
			lacr_rx_stb <= 1'b0;
		end else begin
			lacr_rx_stb <= 1'b0;
			case (state)
				pcs_pkg::WAIT_K, pcs_pkg::GOT_K: begin
					if (state == pcs_pkg::GOT_K && is_cfg) begin
						state <= pcs_pkg::CFG_LO_RX; // /C1/ or /C2/
					end else if (is_start) begin
						RXD <= `PREAMBLE_OCTET; // /S/ stood for preamble
						RX_DV <= 1'b1;
						RX_ER <= 1'b0;
						state <= pcs_pkg::IN_FRAME;
					end else begin
						state <= is_comma ? pcs_pkg::GOT_K : pcs_pkg::WAIT_K;
					end
				end
				pcs_pkg::CFG_LO_RX: begin
					lacr_rx[7:0] <= d;
					state <= k ? pcs_pkg::WAIT_K : pcs_pkg::CFG_HI_RX;
				end
				pcs_pkg::CFG_HI_RX: begin
					lacr_rx[15:8] <= d;
					lacr_rx_stb <= !k && !err; // Word valid with strobe
					state <= pcs_pkg::WAIT_K;
				end
				pcs_pkg::IN_FRAME: begin
					if (is_comma || (k && d == `K29_7)) begin
						RX_DV <= 1'b0; // /T/ or a lost /T/
						RX_ER <= 1'b0;
						state <= is_comma ? pcs_pkg::GOT_K : pcs_pkg::WAIT_K;
					end else begin
						RXD <= d;
						RX_ER <= err || k; // /V/ or any stray control code
					end
				end
				default: state <= pcs_pkg::WAIT_K;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/tx_pcs.sv ====
// Transmit PCS
// Idle and config ordered sets, /S/ ... /T/ /R/ frame encapsulation
`default_nettype none
`include "gmii_link_defines.svh"

module tx_pcs (
	input  wire                  GTX_CLK,
	input  wire                  arst_n,
	input  wire pcs_pkg::octet_t TXD,
	input  wire                  tx_en,
	input  wire                  TX_ER,
	input  wire an_pkg::lacr_t   lacr_out,
	input  wire                  cfg_en,
	input  wire                  tx_disp,
	output pcs_pkg::char_t       tx_char
);

	pcs_pkg::tx_state_e state;
	pcs_pkg::octet_t    txd_q;
	logic               en_q, er_q;
	logic               lag; // Frame runs one cycle late, it arrived mid-set
	logic               odd; // Slot parity, sets start on even slots
	logic               cfg_alt; // 0 = /C1/, 1 = /C2/
	logic               src_en, src_er;
	pcs_pkg::octet_t    src_d;

	assign src_en = lag ? en_q : tx_en;
	assign src_er = lag ? er_q : TX_ER;
	assign src_d = lag ? txd_q : TXD;

	always_ff @(posedge GTX_CLK)
		txd_q <= TXD;

	always_ff @(posedge GTX_CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= pcs_pkg::IDLE_K;
			tx_char <= {1'b1, `K28_5};
			en_q <= 1'b0;
			er_q <= 1'b0;
			lag <= 1'b0;
			odd <= 1'b0;
			cfg_alt <= 1'b0;
		end else begin
			en_q <= tx_en;
			er_q <= TX_ER;
			odd <= ~odd;
			case (state)
				pcs_pkg::IDLE_K, pcs_pkg::CFG_K: begin // Set boundary
					if (src_en) begin
						tx_char <= {1'b1, `K27_7}; // /S/ replaces first preamble octet
						state <= pcs_pkg::DATA;
					end else begin
						tx_char <= {1'b1, `K28_5};
						state <= cfg_en ? pcs_pkg::CFG_D : pcs_pkg::IDLE_D;
					end
				end
				pcs_pkg::IDLE_D: begin
					tx_char <= {1'b0, tx_disp ? `D5_6 : `D16_2}; // tx_disp is RD before the K28.5
					lag <= tx_en;
					state <= cfg_en ? pcs_pkg::CFG_K : pcs_pkg::IDLE_K;
				end
				pcs_pkg::CFG_D: begin
					tx_char <= {1'b0, cfg_alt ? `D2_2 : `D21_5};
					state <= pcs_pkg::CFG_LO;
				end
				pcs_pkg::CFG_LO: begin
					tx_char <= {1'b0, lacr_out[7:0]};
					state <= pcs_pkg::CFG_HI;
				end
				pcs_pkg::CFG_HI: begin
					tx_char <= {1'b0, lacr_out[15:8]};
					cfg_alt <= ~cfg_alt;
					lag <= tx_en;
					state <= cfg_en ? pcs_pkg::CFG_K : pcs_pkg::IDLE_K;
				end
				pcs_pkg::DATA: begin
					if (!src_en) begin
						tx_char <= {1'b1, `K29_7}; // /T/
						lag <= 1'b0;
						state <= pcs_pkg::END_T;
					end else if (src_er) begin
						tx_char <= {1'b1, `K30_7};
					end else begin
						tx_char <= {1'b0, src_d};
					end
				end
				pcs_pkg::END_T: begin
					tx_char <= {1'b1, `K23_7}; // /R/
					if (odd) begin
						lag <= tx_en;
						state <= pcs_pkg::IDLE_K;
					end else begin
						state <= pcs_pkg::END_R; // Second /R/ to even up
					end
				end
				pcs_pkg::END_R: begin
					tx_char <= {1'b1, `K23_7};
					lag <= tx_en;
					state <= pcs_pkg::IDLE_K;
				end
				default: state <= pcs_pkg::IDLE_K;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/dec_8b10b.sv ====
// 8b/10b decoder
// Registers the character with code and disparity error flags
`default_nettype none

module dec_8b10b (
	input  wire                         GTX_CLK,
	input  wire                         arst_n,
	input  wire pcs_pkg::code_group_t   rxdata,
	output pcs_pkg::char_t              rx_char,
	output logic                        code_err,
	output logic                        disp_err
);

	logic [5:0] in6;
	logic [3:0] in4, in4x;
	logic [4:0] x;
	logic [2:0] y;
	logic       ok6, ok4, k28, alt, k, alt_ok;
	logic       rd, rd6, rd4, de6, de4;

	assign in6 = rxdata[9:4];
	assign in4 = rxdata[3:0];
	assign k28 = (in6 == 6'b001111) || (in6 == 6'b110000);
	assign in4x = (in6 == 6'b110000) ? ~in4 : in4; // Undo K28 4b inversion

	always_comb begin
		x = 5'd28;
		ok6 = k28;
		for (int i = 0; i < 32; i++) begin
			if (in6 == pcs_pkg::CODE_6B[i] ||
				(in6 == ~pcs_pkg::CODE_6B[i] && pcs_pkg::flip6(pcs_pkg::CODE_6B[i]))) begin
				x = 5'(i);
				ok6 = 1'b1;
			end
		end
		alt = (in4x == 4'b0111) || (in4x == 4'b1000);
		y = 3'd7;
		ok4 = alt;
		for (int j = 0; j < 8; j++) begin
			if (in4x == pcs_pkg::CODE_4B[j] ||
				(in4x == ~pcs_pkg::CODE_4B[j] && pcs_pkg::flip4(pcs_pkg::CODE_4B[j]))) begin
				y = 3'(j);
				ok4 = 1'b1;
			end
		end
		k = k28 || (alt && (x == 5'd23 || x == 5'd27 || x == 5'd29 || x == 5'd30));
		alt_ok = !alt || k ||
			x == 5'd11 || x == 5'd13 || x == 5'd14 || x == 5'd17 || x == 5'd18 || x == 5'd20;

		// Imbalance of the same sign as current disparity is illegal
		de6 = ($countones(in6) > 3 && rd) || ($countones(in6) < 3 && !rd);
		rd6 = ($countones(in6) > 3) ? 1'b1 : ($countones(in6) < 3) ? 1'b0 : rd;
		de4 = ($countones(in4) > 2 && rd6) || ($countones(in4) < 2 && !rd6);
		rd4 = ($countones(in4) > 2) ? 1'b1 : ($countones(in4) < 2) ? 1'b0 : rd6;
	end

	always_ff @(posedge GTX_CLK or negedge arst_n) begin
		if (!arst_n) begin
			rx_char <= '0;
			code_err <= 1'b0;
			disp_err <= 1'b0;
			rd <= 1'b0; // Negative at start
		end else begin
			rx_char <= {k, y, x};
			code_err <= !(ok6 && ok4 && alt_ok);
			disp_err <= de6 || de4;
			rd <= rd4;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/enc_8b10b.sv ====
// 8b/10b encoder
// One character per cycle, output and running disparity registered together
`default_nettype none

module enc_8b10b (
	input  wire                 GTX_CLK,
	input  wire                 arst_n,
	input  wire pcs_pkg::char_t tx_char,
	output pcs_pkg::code_group_t txdata,
	output logic                tx_disp // 1 = positive
);

	logic [4:0] x;
	logic [2:0] y;
	logic       k, k28, alt;
	logic [5:0] c6, e6;
	logic [3:0] c4, e4;
	logic       rd6, rd4, inv4;

	assign x = tx_char[4:0];
	assign y = tx_char[7:5];
	assign k = tx_char[8];
	assign k28 = k && (x == 5'd28);

	always_comb begin
		c6 = k28 ? 6'b001111 : pcs_pkg::CODE_6B[x]; // K23/27/29/30 share the data 6b
		e6 = (pcs_pkg::flip6(c6) && tx_disp) ? ~c6 : c6;
		rd6 = ($countones(c6) != 3) ? ~tx_disp : tx_disp;

		// A7 avoids a run of five in e i f g h
		alt = (y == 3'd7) && (k ||
			(!rd6 && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
			(rd6 && (x == 5'd11 || x == 5'd13 || x == 5'd14)));
		c4 = alt ? 4'b0111 : pcs_pkg::CODE_4B[y];

		// K28 neutral 4b codes run opposite to data
		if (k28 && !pcs_pkg::flip4(c4))
			inv4 = !rd6;
		else
			inv4 = pcs_pkg::flip4(c4) && rd6;
		e4 = inv4 ? ~c4 : c4;
		rd4 = ($countones(c4) != 2) ? ~rd6 : rd6;
	end

	always_ff @(posedge GTX_CLK or negedge arst_n) begin
		if (!arst_n) begin
			txdata <= '0;
			tx_disp <= 1'b0; // Start negative
		end else begin
			txdata <= {e6, e4};
			tx_disp <= rd4;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/an_pkg.sv ====
// Auto-negotiation types
// Configuration word, status word and negotiation states
`default_nettype none

package an_pkg;

	typedef logic [15:0] lacr_t;

	// {pause[1:0], hd, fd, los, ack seen, state}
	typedef logic [8:0] an_status_t;

	typedef enum logic [2:0] {
		AN_RESTART     = 3'd0,
		ABILITY_DETECT = 3'd1,
		ACK_DETECT     = 3'd2,
		COMPLETE_ACK   = 3'd3,
		IDLE_DETECT    = 3'd4,
		LINK_OK        = 3'd5
	} an_state_e;

endpackage

`default_nettype wire

// ==== hdl/pcs_pkg.sv ====
// PCS types
// Octets, codec characters, code groups and the ordered-set state machines
`default_nettype none

package pcs_pkg;

	typedef logic [7:0] octet_t;
	typedef logic [8:0] char_t; // K flag in bit 8
	typedef logic [9:0] code_group_t; // abcdei fghj, a in bit 9

	typedef enum logic [3:0] {
		IDLE_K, IDLE_D, CFG_K, CFG_D, CFG_LO, CFG_HI, DATA, END_T, END_R
	} tx_state_e;

	typedef enum logic [2:0] {
		WAIT_K, GOT_K, CFG_LO_RX, CFG_HI_RX, IN_FRAME
	} rx_state_e;

	// 5b/6b and 3b/4b codes at negative disparity
	localparam logic [5:0] CODE_6B [32] = '{
		6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
		6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
		6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
		6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
	};
	localparam logic [3:0] CODE_4B [8] = '{
		4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
	};

	// Sub-blocks that change form with running disparity
	function automatic logic flip6(input logic [5:0] c);
		return ($countones(c) != 3) || (c == 6'b111000);
	endfunction

	function automatic logic flip4(input logic [3:0] c);
		return ($countones(c) != 2) || (c == 4'b1100);
	endfunction

endpackage

`default_nettype wire

// ==== hdl/gmii_link_defines.svh ====
// Link block constants
// Control and ordered-set octets, local ability, link timer
`ifndef GMII_LINK_DEFINES_SVH
`define GMII_LINK_DEFINES_SVH

// Control octets, sent with the K flag set
`define K28_5 8'hBC // Comma, leads idle and config sets
`define K27_7 8'hFB // Start of packet /S/
`define K29_7 8'hFD // End of packet /T/
`define K23_7 8'hF7 // Carrier extend /R/
`define K30_7 8'hFE // Error propagation /V/

// Data octets of the ordered sets
`define D21_5 8'hB5 // /C1/
`define D2_2 8'h42 // /C2/
`define D5_6 8'hC5 // /I1/, flips disparity back
`define D16_2 8'h50 // /I2/, keeps disparity

// Negotiation
`define AN_ABILITY 16'h0020 // Full duplex only
`define AN_ACK_BIT 14
`define AN_LINK_TIMER 1250000 // Cycles of GTX_CLK

`define PREAMBLE_OCTET 8'h55 // Stands in for /S/ on RXD

`endif
